// ==== apb_settings_port.sv ====
`include "radio_core_macros.svh"

module apb_settings_port
   import radio_core_pkg::*;
(
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   input  logic                   psel_i,
   input  logic                   penable_i,
   input  logic                   pwrite_i,
   input  logic [`APB_ADDR_W-1:0] paddr_i,
   input  logic [31:0]            pwdata_i,
   input  logic [31:0]            rb_data_i,
   output logic [31:0]            prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,
   output set_bus_t               set_bus_o,
   output logic [2:0]             rb_sel_o,
   output logic                   rb_read_o
);

   logic     access;
   logic     rb_space;
   logic     set_write;
   logic     rb_read;
   logic     bad_access;
   set_bus_t set_bus_q;

   ////////////////////////////////////////
   // Access phase decode
   ////////////////////////////////////////

   assign access   = psel_i & penable_i;
   assign rb_space = paddr_i[11];

   // Writes go to settings space, reads to readback space
   assign set_write  = access & pwrite_i & ~rb_space;
   assign rb_read    = access & ~pwrite_i & rb_space;
   assign bad_access = access & (pwrite_i ? rb_space : ~rb_space);

   // Zero wait states
   assign pready_o  = 1'b1;
   assign pslverr_o = bad_access;

   // Readback word comes straight back, wrong-space reads give zero
   assign rb_sel_o  = paddr_i[4:2];
   assign rb_read_o = rb_read;
   assign prdata_o  = rb_read ? rb_data_i : 32'd0;

   ////////////////////////////////////////
   // Settings beat register
   ////////////////////////////////////////

   // Strobe is the only control bit
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         set_bus_q.stb <= 1'b0;
      end else begin
         set_bus_q.stb <= set_write;
      end
   end

   // Address and data ride along, only meaningful with stb
   always_ff @(posedge dsp_clk) begin
      if (set_write) begin
         set_bus_q.addr <= paddr_i[9:2];
         set_bus_q.data <= pwdata_i;
      end
   end

   assign set_bus_o = set_bus_q;

endmodule

// ==== misc_control_regs.sv ====
`include "radio_core_macros.svh"

module misc_control_regs
   import radio_core_pkg::*;
(
   input  logic          dsp_clk,
   input  logic          por_rst,
   input  set_bus_t      set_bus_i,
   input  board_status_t board_i,
   output ctrl_outs_t    ctrl_o,
   output logic [7:0]    leds_o
);

   localparam logic [7:0] addr_clk     = `SR_MISC + 8'd0;
   localparam logic [7:0] addr_serdes  = `SR_MISC + 8'd1;
   localparam logic [7:0] addr_adc     = `SR_MISC + 8'd2;
   localparam logic [7:0] addr_led_sw  = `SR_MISC + 8'd3;
   localparam logic [7:0] addr_phy     = `SR_MISC + 8'd4;
   localparam logic [7:0] addr_led_src = `SR_MISC + 8'd6;

   logic [4:0] clk_reg;
   logic [3:0] serdes_reg;
   logic [3:0] adc_reg;
   logic [7:0] led_sw;
   logic       phy_reset;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   ////////////////////////////////////////
   // Settings registers
   ////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clk_reg    <= 5'd0;
         serdes_reg <= 4'd0;
         adc_reg    <= 4'd0;
         led_sw     <= 8'd0;
         phy_reset  <= 1'b0;
         led_src    <= `LED_SRC_RESET;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            addr_clk: begin
               clk_reg <= set_bus_i.data[4:0];
            end
            addr_serdes: begin
               serdes_reg <= set_bus_i.data[3:0];
            end
            addr_adc: begin
               adc_reg <= set_bus_i.data[3:0];
            end
            addr_led_sw: begin
               led_sw <= set_bus_i.data[7:0];
            end
            addr_phy: begin
               phy_reset <= set_bus_i.data[0];
            end
            addr_led_src: begin
               led_src <= set_bus_i.data[7:0];
            end
            default: begin
               // Other addresses belong to other stages
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Output mapping
   ////////////////////////////////////////

   always_comb begin
      {ctrl_o.clock_ready, ctrl_o.clk_en, ctrl_o.clk_sel} = clk_reg;
      {ctrl_o.ser_enable, ctrl_o.ser_prbsen, ctrl_o.ser_loopen, ctrl_o.ser_rx_en} = serdes_reg;
      {ctrl_o.adc_oe_a, ctrl_o.adc_on_a, ctrl_o.adc_oe_b, ctrl_o.adc_on_b} = adc_reg;
      // PHY reset pin is active low
      ctrl_o.phy_resetn = ~phy_reset;
   end

   // Hardware LED sources, bit 0 has none
   assign led_hw = {3'b000, board_i.tx_run, board_i.rx_run, board_i.clk_status,
                    board_i.serdes_link_up, 1'b0};

   // Source bit 1 picks hardware, 0 picks software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// ==== radio_core_macros.svh ====
`ifndef RADIO_CORE_MACROS_SVH
`define RADIO_CORE_MACROS_SVH

////////////////////////////////////////
// Settings bus map
////////////////////////////////////////

// Control bank, offsets 0 to 6
`define SR_MISC 8'd0

// Timekeeper, offsets 0 to 2
`define SR_TIME64 8'd10

////////////////////////////////////////
// Readback words
////////////////////////////////////////

`define RB_COMPAT 3'd0
`define RB_TIME_HI 3'd1
`define RB_TIME_LO 3'd2
`define RB_PPS_HI 3'd3
`define RB_PPS_LO 3'd4
`define RB_STATUS 3'd5

// Bump major when the register map changes
`define COMPAT_MAJOR 16'd9
`define COMPAT_MINOR 16'd0

// Hardware drives LEDs 4..1 out of reset
`define LED_SRC_RESET 8'h1E

// Bit 11 picks readback space
`define APB_ADDR_W 12

`endif

// ==== radio_core_pkg.sv ====
package radio_core_pkg;

   ////////////////////////////////////////
   // Settings bus
   ////////////////////////////////////////

   // One write beat, stb is a single-cycle pulse
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   ////////////////////////////////////////
   // Board side
   ////////////////////////////////////////

   // Inputs that show up in status and on the LEDs
   typedef struct packed {
      logic button;
      logic clk_status;
      logic serdes_link_up;
      logic rx_run;
      logic tx_run;
   } board_status_t;

   // Clock gen, SERDES, ADC and PHY controls
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_resetn;
   } ctrl_outs_t;

   // Timekeeper results
   typedef struct packed {
      logic [63:0] vita_time;
      logic [63:0] vita_time_pps;
      logic        set_pending;
      logic        pps_int;
   } time_info_t;

endpackage

// ==== radio_core_top.sv ====
`include "radio_core_macros.svh"

module radio_core_top
   import radio_core_pkg::*;
(
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   input  logic                   psel_i,
   input  logic                   penable_i,
   input  logic                   pwrite_i,
   input  logic [`APB_ADDR_W-1:0] paddr_i,
   input  logic [31:0]            pwdata_i,
   input  logic                   pps_i,
   input  logic                   button_i,
   input  logic                   clk_status_i,
   input  logic                   serdes_link_up_i,
   input  logic                   rx_run_i,
   input  logic                   tx_run_i,
   output logic [31:0]            prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,
   output ctrl_outs_t             ctrl_o,
   output logic [7:0]             leds_o,
   output logic                   pps_int_o
);

   set_bus_t      set_bus;
   board_status_t board;
   time_info_t    time_info;
   logic [2:0]    rb_sel;
   logic          rb_read;
   logic [31:0]   rb_data;

   assign board = '{button:         button_i,
                    clk_status:     clk_status_i,
                    serdes_link_up: serdes_link_up_i,
                    rx_run:         rx_run_i,
                    tx_run:         tx_run_i};

   apb_settings_port u_apb (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
      .paddr_i(paddr_i), .pwdata_i(pwdata_i), .rb_data_i(rb_data),
      .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
      .set_bus_o(set_bus), .rb_sel_o(rb_sel), .rb_read_o(rb_read)
   );

   misc_control_regs u_misc (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_bus_i(set_bus),
      .board_i(board), .ctrl_o(ctrl_o), .leds_o(leds_o)
   );

   vita_timekeeper u_time (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_bus_i(set_bus),
      .pps_i(pps_i), .time_o(time_info)
   );

   status_readback u_rb (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .rb_sel_i(rb_sel), .rb_read_i(rb_read),
      .time_i(time_info), .board_i(board), .leds_i(leds_o), .rb_data_o(rb_data)
   );

   assign pps_int_o = time_info.pps_int;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the radio core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_radio_core -f verilog.f -o sim_radio_core
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_radio_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" sim.log; then
   exit 1
fi
exit 0

// ==== status_readback.sv ====
`include "radio_core_macros.svh"

module status_readback
   import radio_core_pkg::*;
(
   input  logic          dsp_clk,
   input  logic          por_rst,
   input  logic [2:0]    rb_sel_i,
   input  logic          rb_read_i,
   input  time_info_t    time_i,
   input  board_status_t board_i,
   input  logic [7:0]    leds_i,
   output logic [31:0]   rb_data_o
);

   logic [31:0] time_lo_snap;
   logic [31:0] pps_lo_snap;
   logic [31:0] status_word;

   ////////////////////////////////////////
   // Coherent 64-bit reads
   ////////////////////////////////////////

   // High word read freezes the matching low word
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_lo_snap <= 32'd0;
         pps_lo_snap  <= 32'd0;
      end else if (rb_read_i) begin
         if (rb_sel_i == `RB_TIME_HI) begin
            time_lo_snap <= time_i.vita_time[31:0];
         end
         if (rb_sel_i == `RB_PPS_HI) begin
            pps_lo_snap <= time_i.vita_time_pps[31:0];
         end
      end
   end

   assign status_word = {20'd0, board_i.button, board_i.clk_status,
                         board_i.serdes_link_up, time_i.set_pending, leds_i};

   // Word select
   always_comb begin
      case (rb_sel_i)
         `RB_COMPAT:  rb_data_o = {`COMPAT_MAJOR, `COMPAT_MINOR};
         `RB_TIME_HI: rb_data_o = time_i.vita_time[63:32];
         `RB_TIME_LO: rb_data_o = time_lo_snap;
         `RB_PPS_HI:  rb_data_o = time_i.vita_time_pps[63:32];
         `RB_PPS_LO:  rb_data_o = pps_lo_snap;
         `RB_STATUS:  rb_data_o = status_word;
         default:     rb_data_o = 32'd0;
      endcase
   end

endmodule

// ==== tb_radio_core.sv ====
`include "radio_core_macros.svh"

module tb_radio_core
   import radio_core_pkg::*;
();

   localparam int N_TESTS         = 6;
   localparam int PPS_WAIT_CYCLES = 40;
   localparam int TIMEOUT_CYCLES  = N_TESTS * 200 + PPS_WAIT_CYCLES;
   localparam int REF_CTRL        = 0;
   localparam int REF_LEDS        = 1;
   localparam int REF_STATUS      = 2;

   logic                   dsp_clk;
   logic                   por_rst;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [`APB_ADDR_W-1:0] paddr;
   logic [31:0]            pwdata;
   logic                   pps;
   board_status_t          board;
   logic [31:0]            prdata;
   logic                   pready;
   logic                   pslverr;
   ctrl_outs_t             ctrl;
   logic [7:0]             leds;
   logic                   pps_int;

   // Model of the written registers
   logic [4:0]  m_clk;
   logic [3:0]  m_serdes;
   logic [3:0]  m_adc;
   logic [7:0]  m_led_sw;
   logic        m_phy_rst;
   logic [7:0]  m_led_src;
   logic        m_pending;

   logic [31:0] rng_state;
   logic [31:0] rd_data;
   int          errors;
   int          checks;
   int          tests_done;

   radio_core_top u_dut (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
      .paddr_i(paddr), .pwdata_i(pwdata), .pps_i(pps),
      .button_i(board.button), .clk_status_i(board.clk_status),
      .serdes_link_up_i(board.serdes_link_up), .rx_run_i(board.rx_run),
      .tx_run_i(board.tx_run), .prdata_o(prdata), .pready_o(pready),
      .pslverr_o(pslverr), .ctrl_o(ctrl), .leds_o(leds), .pps_int_o(pps_int)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #4 dsp_clk = ~dsp_clk;
   end

   // Watchdog
   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge dsp_clk);
      $display("Run timed out after %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // Expected ctrl, leds or status word from the register model
   function automatic logic [31:0] reference_value(input int what);
      ctrl_outs_t exp_ctrl;
      logic [7:0] hw;
      logic [7:0] exp_leds;
      exp_ctrl.clock_ready = m_clk[4];
      exp_ctrl.clk_en      = m_clk[3:2];
      exp_ctrl.clk_sel     = m_clk[1:0];
      {exp_ctrl.ser_enable, exp_ctrl.ser_prbsen, exp_ctrl.ser_loopen,
       exp_ctrl.ser_rx_en} = m_serdes;
      {exp_ctrl.adc_oe_a, exp_ctrl.adc_on_a, exp_ctrl.adc_oe_b, exp_ctrl.adc_on_b} = m_adc;
      exp_ctrl.phy_resetn = !m_phy_rst;
      hw = {3'b000, board.tx_run, board.rx_run, board.clk_status, board.serdes_link_up, 1'b0};
      for (int i = 0; i < 8; i++) begin
         exp_leds[i] = m_led_src[i] ? hw[i] : m_led_sw[i];
      end
      case (what)
         REF_CTRL: return {18'd0, exp_ctrl};
         REF_LEDS: return {24'd0, exp_leds};
         default:  return {20'd0, board.button, board.clk_status, board.serdes_link_up,
                           m_pending, exp_leds};
      endcase
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
      end
   endtask

   function automatic logic [`APB_ADDR_W-1:0] set_addr(input logic [7:0] a);
      return {2'b00, a, 2'b00};
   endfunction

   function automatic logic [`APB_ADDR_W-1:0] rb_addr(input logic [2:0] w);
      return {1'b1, 6'd0, w, 2'b00};
   endfunction

   // Setup then access phase, response sampled mid access phase
   task automatic apb_access(input logic write, input logic [`APB_ADDR_W-1:0] addr,
                             input logic [31:0] data);
      @(negedge dsp_clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = data;
      @(negedge dsp_clk);
      penable = 1'b1;
      #1;
      rd_data = prdata;
      check_value("pready_o", 64'd1, 64'(pready));
      // Error only for a write to readback space or a read from settings space
      check_value("pslverr_o", 64'(write == addr[11]), 64'(pslverr));
      @(negedge dsp_clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic read_check(input string name, input logic [2:0] word,
                             input logic [31:0] expected);
      apb_access(1'b0, rb_addr(word), 32'd0);
      check_value(name, 64'(expected), 64'(rd_data));
   endtask

   // Write one control register, then compare ctrl_o once the value has landed
   task automatic ctrl_write_check(input logic [7:0] offset, input logic [31:0] data);
      apb_access(1'b1, set_addr(`SR_MISC + offset), data);
      repeat (2) @(negedge dsp_clk);
      check_value("ctrl_o", 64'(reference_value(REF_CTRL)), 64'(ctrl));
   endtask

   task automatic end_test(input string name, input int errors_before);
      tests_done++;
      $display("[%0d] %s done, %0d new errors", tests_done, name, errors - errors_before);
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      logic [31:0] r;
      logic [31:0] hi;
      logic [31:0] hi2;
      ctrl_outs_t  ctrl_before;
      logic [7:0]  leds_before;
      logic        seen;
      int          e0;
      rng_state  = 32'he50bde66;
      errors     = 0;
      checks     = 0;
      tests_done = 0;
      por_rst    = 1'b1;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = 32'd0;
      pps        = 1'b0;
      // Board inputs high so the reset LED source shows on leds_o
      board      = '1;
      m_clk      = 5'd0;
      m_serdes   = 4'd0;
      m_adc      = 4'd0;
      m_led_sw   = 8'd0;
      m_phy_rst  = 1'b0;
      m_led_src  = 8'h1E;
      m_pending  = 1'b0;
      repeat (5) @(negedge dsp_clk);
      por_rst = 1'b0;

      e0 = errors;
      check_value("ctrl_o", 64'(reference_value(REF_CTRL)), 64'(ctrl));
      check_value("leds_o", 64'(reference_value(REF_LEDS)), 64'(leds));
      read_check("rb_compat", `RB_COMPAT, 32'h0009_0000);
      read_check("rb_time_hi", `RB_TIME_HI, 32'd0);
      end_test("reset state", e0);

      e0 = errors;
      for (int i = 0; i < 4; i++) begin
         r = lcg_next();
         m_clk = r[4:0];
         ctrl_write_check(8'd0, r);
         r = lcg_next();
         m_serdes = r[3:0];
         ctrl_write_check(8'd1, r);
         r = lcg_next();
         m_adc = r[3:0];
         ctrl_write_check(8'd2, r);
         r = lcg_next();
         m_phy_rst = r[0];
         ctrl_write_check(8'd4, r);
      end
      end_test("control registers", e0);

      e0 = errors;
      for (int i = 0; i < 4; i++) begin
         r = lcg_next();
         board = r[4:0];
         m_led_src = r[15:8];
         m_led_sw = r[23:16];
         apb_access(1'b1, set_addr(`SR_MISC + 8'd6), {24'd0, m_led_src});
         apb_access(1'b1, set_addr(`SR_MISC + 8'd3), {24'd0, m_led_sw});
         repeat (2) @(negedge dsp_clk);
         check_value("leds_o", 64'(reference_value(REF_LEDS)), 64'(leds));
         read_check("rb_status", `RB_STATUS, reference_value(REF_STATUS));
      end
      end_test("led mux", e0);

      e0 = errors;
      hi = lcg_next();
      apb_access(1'b1, set_addr(`SR_TIME64 + 8'd0), hi);
      apb_access(1'b1, set_addr(`SR_TIME64 + 8'd1), 32'd0);
      apb_access(1'b1, set_addr(`SR_TIME64 + 8'd2), 32'd1);
      read_check("rb_time_hi", `RB_TIME_HI, hi);
      apb_access(1'b0, rb_addr(`RB_TIME_LO), 32'd0);
      checks++;
      // Only a few cycles pass between the load and the high word read
      if (rd_data == 32'd0 || rd_data >= 32'd64) begin
         errors++;
         $display("Error: rb_time_lo snapshot 0x%0h outside 0x1 to 0x3f", rd_data);
      end
      end_test("set time now", e0);

      e0 = errors;
      hi2 = lcg_next();
      if (hi2 == hi) begin
         hi2 = ~hi;
      end
      apb_access(1'b1, set_addr(`SR_TIME64 + 8'd0), hi2);
      apb_access(1'b1, set_addr(`SR_TIME64 + 8'd2), 32'd0);
      m_pending = 1'b1;
      read_check("rb_status", `RB_STATUS, reference_value(REF_STATUS));
      read_check("rb_time_hi", `RB_TIME_HI, hi);
      pps = 1'b1;
      seen = 1'b0;
      for (int i = 0; i < PPS_WAIT_CYCLES && !seen; i++) begin
         @(negedge dsp_clk);
         seen = pps_int;
      end
      pps = 1'b0;
      if (!seen) begin
         errors++;
         $display("pps_int_o never pulsed after the rise on pps_i");
      end
      m_pending = 1'b0;
      read_check("rb_time_hi", `RB_TIME_HI, hi2);
      read_check("rb_pps_hi", `RB_PPS_HI, hi);
      read_check("rb_status", `RB_STATUS, reference_value(REF_STATUS));
      end_test("set time at pps", e0);

      e0 = errors;
      ctrl_before = ctrl;
      leds_before = leds;
      apb_access(1'b0, set_addr(`SR_MISC + 8'd3), 32'd0);
      check_value("prdata_o", 64'd0, 64'(rd_data));
      // Bits 9..2 point at the clock register if the write leaked through
      apb_access(1'b1, rb_addr(3'd0), {27'd0, ~m_clk});
      repeat (2) @(negedge dsp_clk);
      check_value("ctrl_o", 64'(ctrl_before), 64'(ctrl));
      check_value("leds_o", 64'(leds_before), 64'(leds));
      end_test("bad accesses", e0);

      $display("Summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+.
radio_core_pkg.sv
apb_settings_port.sv
misc_control_regs.sv
vita_timekeeper.sv
status_readback.sv
radio_core_top.sv
tb_radio_core.sv

// ==== vita_timekeeper.sv ====
`include "radio_core_macros.svh"

module vita_timekeeper
   import radio_core_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  set_bus_t   set_bus_i,
   input  logic       pps_i,
   output time_info_t time_o
);

   localparam logic [7:0] addr_time_hi = `SR_TIME64 + 8'd0;
   localparam logic [7:0] addr_time_lo = `SR_TIME64 + 8'd1;
   localparam logic [7:0] addr_commit  = `SR_TIME64 + 8'd2;

   logic        pps_meta;
   logic        pps_sync;
   logic        pps_dly;
   logic        pps_edge;
   logic [31:0] stage_hi;
   logic [31:0] stage_lo;
   logic        load_now;
   logic        arm_pps;
   logic [63:0] vita_time;
   logic [63:0] vita_time_pps;
   logic        set_pending;
   logic        pps_int;

   ////////////////////////////////////////
   // PPS sync and edge detect
   ////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_dly  <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_dly  <= pps_sync;
      end
   end

   assign pps_edge = pps_sync & ~pps_dly;

   ////////////////////////////////////////
   // Staged time words
   ////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (set_bus_i.stb && (set_bus_i.addr == addr_time_hi)) begin
         stage_hi <= set_bus_i.data;
      end
      if (set_bus_i.stb && (set_bus_i.addr == addr_time_lo)) begin
         stage_lo <= set_bus_i.data;
      end
   end

   // Commit, bit 0 picks load now vs wait for PPS
   assign load_now = set_bus_i.stb && (set_bus_i.addr == addr_commit) && set_bus_i.data[0];
   assign arm_pps  = set_bus_i.stb && (set_bus_i.addr == addr_commit) && !set_bus_i.data[0];

   ////////////////////////////////////////
   // Time counter
   ////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time     <= 64'd0;
         vita_time_pps <= 64'd0;
         set_pending   <= 1'b0;
         pps_int       <= 1'b0;
      end else begin
         pps_int <= pps_edge;
         // Latch the running time, load below does not affect it
         if (pps_edge) begin
            vita_time_pps <= vita_time;
         end
         if (load_now) begin
            vita_time   <= {stage_hi, stage_lo};
            set_pending <= 1'b0;
         end else if (arm_pps) begin
            vita_time   <= vita_time + 64'd1;
            set_pending <= 1'b1;
         end else if (pps_edge && set_pending) begin
            vita_time   <= {stage_hi, stage_lo};
            set_pending <= 1'b0;
         end else begin
            vita_time <= vita_time + 64'd1;
         end
      end
   end

   assign time_o.vita_time     = vita_time;
   assign time_o.vita_time_pps = vita_time_pps;
   assign time_o.set_pending   = set_pending;
   assign time_o.pps_int       = pps_int;

endmodule
